// ==== common/spi_pkg.sv ====
`default_nettype none

package spi_pkg;

	// --------------------------------------------------
	// stream and serial widths
	// --------------------------------------------------
	localparam int WORD_W = 32;  // input/output stream word
	localparam int BYTE_W = 8;   // one byte on the wire
	localparam int LEN_W  = 12;  // byte count field

	// command word layout
	localparam int WR_LEN_LSB = 0;   // bytes to write
	localparam int RD_LEN_LSB = 16;  // bytes to read

	typedef struct packed {
		logic [LEN_W-1:0] rd_len;
		logic [LEN_W-1:0] wr_len;
	} cmd_t;

	typedef enum logic [2:0] {
		idle,      // waiting for a command
		select,    // cs_n low, no edge yet
		write,     // shifting out write bytes
		read,      // shifting in read bytes
		deselect   // cs_n high gap
	} seq_state_e;

endpackage

`default_nettype wire

// ==== common/spi_rx_if.sv ====
`default_nettype none

// received bytes towards the output FIFO, credits coming back
interface spi_rx_if;
	import spi_pkg::*;

	logic              rx_valid;  // one cycle per completed byte
	logic [BYTE_W-1:0] rx_data;
	logic              rx_last;   // final byte of the transaction
	logic              credit;    // one cycle per byte leaving the FIFO

	modport seq (
		output rx_valid,
		output rx_data,
		output rx_last,
		input  credit
	);

	modport out_buf (
		input  rx_valid,
		input  rx_data,
		input  rx_last,
		output credit
	);

endinterface

`default_nettype wire

// ==== common/spi_shift_if.sv ====
`default_nettype none

// byte level control of the shifter
interface spi_shift_if;
	import spi_pkg::*;

	logic              load;       // start a byte, one cycle
	logic [BYTE_W-1:0] tx_data;
	logic              capture;    // byte is a read byte
	logic              byte_done;  // eighth sample taken, one cycle
	logic [BYTE_W-1:0] rx_data;

	modport seq (
		output load,
		output tx_data,
		output capture,
		input  byte_done,
		input  rx_data
	);

	modport shift (
		input  load,
		input  tx_data,
		input  capture,
		output byte_done,
		output rx_data
	);

endinterface

`default_nettype wire

// ==== spi_engine/spi_clock_gen.sv ====
`default_nettype none

module spi_clock_gen #(
	parameter int CLK_DIV = 2
) (
	input  wire  aclk,
	input  wire  aresetn,
	input  wire  run,
	output logic sclk,
	output logic rise,
	output logic fall
);

	localparam int CNT_W = (CLK_DIV > 0) ? $clog2(CLK_DIV + 1) : 1;

	logic [CNT_W-1:0] cnt;
	logic             half_end;

	assign half_end = (cnt == CNT_W'(CLK_DIV));  // last cycle of a half period

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			cnt  <= '0;
			sclk <= 1'b0;
			rise <= 1'b0;
			fall <= 1'b0;
		end else if (!run) begin
			cnt  <= '0;    // fresh half period on restart
			sclk <= 1'b0;
			rise <= 1'b0;
			fall <= 1'b0;
		end else begin
			rise <= half_end && !sclk;  // high with the first sclk high cycle
			fall <= half_end && sclk;
			if (half_end) begin
				cnt  <= '0;
				sclk <= !sclk;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== spi_engine/spi_shifter.sv ====
`default_nettype none

module spi_shifter (
	input  wire        aclk,
	input  wire        aresetn,
	input  wire        rise,
	input  wire        fall,
	input  wire        miso,
	output logic       mosi,
	spi_shift_if.shift sh
);
	import spi_pkg::*;

	logic [BYTE_W-1:0] tx_sr;
	logic [BYTE_W-1:0] rx_sr;
	logic [2:0]        bit_cnt;  // rise ticks seen in this byte

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			tx_sr        <= '0;
			bit_cnt      <= '0;
			sh.byte_done <= 1'b0;
		end else begin
			sh.byte_done <= 1'b0;
			if (sh.load) begin
				tx_sr   <= sh.capture ? '0 : sh.tx_data;  // read bytes send zeros
				bit_cnt <= '0;
			end else begin
				// trailing fall of the previous byte sees bit_cnt 0
				if (fall && (bit_cnt != 3'd0)) begin
					tx_sr <= {tx_sr[BYTE_W-2:0], 1'b0};
				end
				if (rise) begin
					bit_cnt      <= bit_cnt + 3'd1;
					sh.byte_done <= (bit_cnt == 3'd7);
				end
			end
		end
	end

	always_ff @(posedge aclk) begin
		if (rise) begin
			rx_sr <= {rx_sr[BYTE_W-2:0], miso};  // msb first
		end
	end

	assign mosi       = tx_sr[BYTE_W-1];
	assign sh.rx_data = rx_sr;

endmodule

`default_nettype wire

// ==== spi_engine/spi_sequencer.sv ====
`default_nettype none

module spi_sequencer #(
	parameter int OUT_DEPTH = 2
) (
	input  wire                       aclk,
	input  wire                       aresetn,
	input  wire                       word_valid,
	output logic                      word_ready,
	input  wire [spi_pkg::WORD_W-1:0] word,
	input  wire                       rise,
	input  wire                       fall,
	output logic                      run,
	output logic                      cs_n,
	spi_rx_if.seq                     rx,
	spi_shift_if.seq                  sh
);
	import spi_pkg::*;

	localparam int CRED_W = $clog2(OUT_DEPTH + 1);

	seq_state_e        state;
	cmd_t              cmd;
	logic [LEN_W-1:0]  wr_cnt;    // write bytes not yet loaded
	logic [LEN_W-1:0]  rd_cnt;    // read bytes not yet started
	logic [LEN_W-1:0]  half_cnt;  // aclk cycles since last rise
	logic [CRED_W-1:0] credits;
	logic              active;    // byte in the shifter
	logic              free;
	logic              start_wr;
	logic              start_rd;
	logic              start;
	logic              done;

	assign cmd.rd_len = word[RD_LEN_LSB +: LEN_W];
	assign cmd.wr_len = word[WR_LEN_LSB +: LEN_W];

	// --------------------------------------------------
	// byte slot decisions
	// --------------------------------------------------
	assign free     = !active || sh.byte_done;
	assign start_wr = (state == write) && free && (wr_cnt != '0) && word_valid;
	assign start_rd = (state == read) && free && (rd_cnt != '0) && (credits != '0);
	assign start    = start_wr || start_rd;
	assign done     = free && (wr_cnt == '0) && (rd_cnt == '0);

	assign word_ready = (state == idle) || ((state == write) && free && (wr_cnt != '0));

	assign sh.load    = start;
	assign sh.capture = (state == read);
	assign sh.tx_data = word[BYTE_W-1:0];

	assign rx.rx_valid = sh.byte_done && (state == read);
	assign rx.rx_data  = sh.rx_data;
	assign rx.rx_last  = (rd_cnt == '0);  // nothing left to start

	// --------------------------------------------------
	// transaction FSM
	// --------------------------------------------------
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			state    <= idle;
			cs_n     <= 1'b1;
			run      <= 1'b0;
			active   <= 1'b0;
			wr_cnt   <= '0;
			rd_cnt   <= '0;
			half_cnt <= '0;
		end else begin
			if (start) begin
				active <= 1'b1;
				run    <= 1'b1;
			end else begin
				if (sh.byte_done) begin
					active <= 1'b0;
				end
				if (fall && free) begin
					run <= 1'b0;  // no next byte, park sclk low
				end
			end

			case (state)
				idle: begin
					if (word_valid) begin
						wr_cnt <= cmd.wr_len;
						rd_cnt <= cmd.rd_len;
						if ((cmd.wr_len != '0) || (cmd.rd_len != '0)) begin
							state <= select;
							cs_n  <= 1'b0;
						end
					end
				end
				// first low half period of the clock gives cs_n setup
				select: state <= (wr_cnt != '0) ? write : read;
				write, read: begin
					if (start_wr) begin
						wr_cnt <= wr_cnt - 1'b1;
					end
					if (start_rd) begin
						rd_cnt <= rd_cnt - 1'b1;
					end
					if (done && fall) begin
						state <= deselect;  // half_cnt holds the high half length
						cs_n  <= 1'b1;
					end else begin
						half_cnt <= rise ? '0 : half_cnt + 1'b1;
						if ((state == write) && free && (wr_cnt == '0) && (rd_cnt != '0)) begin
							state <= read;
						end
					end
				end
				deselect: begin
					if (half_cnt == '0) begin
						state <= idle;
					end else begin
						half_cnt <= half_cnt - 1'b1;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// spent at byte start, returned as the FIFO drains
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			credits <= CRED_W'(OUT_DEPTH);
		end else begin
			credits <= credits + CRED_W'(rx.credit) - CRED_W'(start_rd);
		end
	end

	a_credit_bound: assert property (@(posedge aclk) disable iff (!aresetn)
		credits <= CRED_W'(OUT_DEPTH));

	a_no_clock_deselected: assert property (@(posedge aclk) disable iff (!aresetn)
		cs_n |-> !run);

endmodule

`default_nettype wire

// ==== src/spi_in_buffer.sv ====
`default_nettype none

module spi_in_buffer (
	input  wire                        aclk,
	input  wire                        aresetn,
	input  wire [spi_pkg::WORD_W-1:0]  s_data,
	input  wire                        s_valid,
	output logic                       s_ready,
	output logic                       word_valid,
	output logic [spi_pkg::WORD_W-1:0] word,
	input  wire                        word_ready
);

	typedef enum logic {
		empty,
		full
	} hold_state_e;

	hold_state_e state;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			state   <= empty;
			s_ready <= 1'b0;
		end else begin
			case (state)
				empty: begin
					if (s_valid && s_ready) begin
						state   <= full;
						s_ready <= 1'b0;
					end else begin
						s_ready <= 1'b1;  // also first rise after reset
					end
				end
				full: begin
					if (word_ready) begin  // sequencer took the word
						state   <= empty;
						s_ready <= 1'b1;
					end
				end
				default: begin
					state   <= empty;
					s_ready <= 1'b0;
				end
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (s_valid && s_ready) begin
			word <= s_data;
		end
	end

	assign word_valid = (state == full);

	a_ready_xor_valid: assert property (@(posedge aclk) disable iff (!aresetn)
		!(s_ready && word_valid));

endmodule

`default_nettype wire

// ==== src/spi_out_buffer.sv ====
`default_nettype none

module spi_out_buffer #(
	parameter int OUT_DEPTH = 2
) (
	input  wire                        aclk,
	input  wire                        aresetn,
	output logic [spi_pkg::WORD_W-1:0] m_data,
	output logic                       m_valid,
	input  wire                        m_ready,
	output logic                       m_last,
	spi_rx_if.out_buf                  rx
);
	import spi_pkg::*;

	localparam int PTR_W = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
	localparam int CNT_W = $clog2(OUT_DEPTH + 1);

	logic [BYTE_W-1:0] mem_data [OUT_DEPTH];
	logic              mem_last [OUT_DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;
	logic              pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign m_valid   = (count != '0);
	assign pop       = m_valid && m_ready;
	assign m_data    = {{(WORD_W - BYTE_W){1'b0}}, mem_data[rd_ptr]};
	assign m_last    = mem_last[rd_ptr];
	assign rx.credit = pop;  // slot freed, sequencer may start a byte

	always_ff @(posedge aclk) begin
		if (rx.rx_valid) begin
			mem_data[wr_ptr] <= rx.rx_data;
			mem_last[wr_ptr] <= rx.rx_last;
		end
	end

	// --------------------------------------------------
	// pointers and fill level
	// --------------------------------------------------
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (rx.rx_valid) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + CNT_W'(rx.rx_valid) - CNT_W'(pop);
		end
	end

	a_no_overflow: assert property (@(posedge aclk) disable iff (!aresetn)
		rx.rx_valid |-> (count < CNT_W'(OUT_DEPTH)));

endmodule

`default_nettype wire

// ==== src/spi_master_top.sv ====
`default_nettype none

module spi_master_top #(
	parameter int CLK_DIV   = 2,
	parameter int OUT_DEPTH = 2
) (
	input  wire                        aclk,
	input  wire                        aresetn,
	// command and write data stream
	input  wire [spi_pkg::WORD_W-1:0]  s_data,
	input  wire                        s_valid,
	output logic                       s_ready,
	// read data stream
	output logic [spi_pkg::WORD_W-1:0] m_data,
	output logic                       m_valid,
	input  wire                        m_ready,
	output logic                       m_last,
	// flash pins
	output logic                       cs_n,
	output logic                       sclk,
	output logic                       mosi,
	input  wire                        miso
);
	import spi_pkg::*;

	logic              word_valid;
	logic              word_ready;
	logic [WORD_W-1:0] word;
	logic              run;
	logic              rise;
	logic              fall;

	spi_rx_if    rx_if ();
	spi_shift_if sh_if ();

	spi_in_buffer in_buf_i (
		.aclk       (aclk),
		.aresetn    (aresetn),
		.s_data     (s_data),
		.s_valid    (s_valid),
		.s_ready    (s_ready),
		.word_valid (word_valid),
		.word       (word),
		.word_ready (word_ready)
	);

	spi_sequencer #(
		.OUT_DEPTH (OUT_DEPTH)
	) seq_i (
		.aclk       (aclk),
		.aresetn    (aresetn),
		.word_valid (word_valid),
		.word_ready (word_ready),
		.word       (word),
		.rise       (rise),
		.fall       (fall),
		.run        (run),
		.cs_n       (cs_n),
		.rx         (rx_if.seq),
		.sh         (sh_if.seq)
	);

	spi_clock_gen #(
		.CLK_DIV (CLK_DIV)
	) clk_gen_i (
		.aclk    (aclk),
		.aresetn (aresetn),
		.run     (run),
		.sclk    (sclk),
		.rise    (rise),
		.fall    (fall)
	);

	spi_shifter shifter_i (
		.aclk    (aclk),
		.aresetn (aresetn),
		.rise    (rise),
		.fall    (fall),
		.miso    (miso),
		.mosi    (mosi),
		.sh      (sh_if.shift)
	);

	spi_out_buffer #(
		.OUT_DEPTH (OUT_DEPTH)
	) out_buf_i (
		.aclk    (aclk),
		.aresetn (aresetn),
		.m_data  (m_data),
		.m_valid (m_valid),
		.m_ready (m_ready),
		.m_last  (m_last),
		.rx      (rx_if.out_buf)
	);

endmodule

`default_nettype wire

// ==== bench/spi_flash_model.sv ====
`default_nettype none

// behavioral serial flash, mode 0
module spi_flash_model (
	input  wire        cs_n,
	input  wire        sclk,
	input  wire        mosi,
	input  int         wr_len,     // write bytes of the current transaction
	output logic       miso,
	output int         bits_seen,  // sclk rises since cs_n fell
	output int         rec_total,  // bytes recorded over the whole run
	output logic [7:0] rec_byte    // most recent byte seen on mosi
);

	logic [7:0] rec_q [$];
	logic [7:0] shift_in;

	function automatic logic [7:0] answer_byte(input int idx);
		return 8'(165 + 29 * idx);  // a5 plus 29 per byte
	endfunction

	// level wanted at the next rising edge
	function automatic logic next_bit(input int nbits);
		logic [7:0] b;
		b = answer_byte(nbits / 8);
		if ((nbits / 8) < wr_len) begin
			return 1'b0;  // still listening
		end
		return b[7 - (nbits % 8)];
	endfunction

	initial begin
		miso      = 1'b0;
		bits_seen = 0;
		rec_total = 0;
		rec_byte  = 8'h00;
		shift_in  = 8'h00;
	end

	always @(negedge cs_n) begin
		bits_seen = 0;
		miso      = next_bit(0);  // first bit ready before the first rise
	end

	always @(posedge sclk) begin
		if (!cs_n) begin
			shift_in  = {shift_in[6:0], mosi};
			bits_seen = bits_seen + 1;
			if ((bits_seen % 8) == 0) begin
				rec_q.push_back(shift_in);
				rec_byte  = shift_in;
				rec_total = rec_q.size();
			end
		end
	end

	always @(negedge sclk) begin
		if (!cs_n) begin
			miso = next_bit(bits_seen);
		end
	end

endmodule

`default_nettype wire

// ==== bench/tb_spi_master.sv ====
`default_nettype none

module tb_spi_master;
	import spi_pkg::*;

	localparam int CLK_DIV     = 2;
	localparam int OUT_DEPTH   = 2;
	localparam int CLK_PERIOD  = 10;
	localparam int DRIVE_DLY   = 1;
	localparam int TOTAL_BYTES = 30;  // all commands below
	localparam int WATCHDOG    = TOTAL_BYTES * 16 * (CLK_DIV + 1) * CLK_PERIOD + 30000;

	logic              aclk = 1'b0;
	logic              aresetn;
	logic [WORD_W-1:0] s_data;
	logic              s_valid;
	logic              s_ready;
	logic [WORD_W-1:0] m_data;
	logic              m_valid;
	logic              m_ready;
	logic              m_last;
	logic              cs_n;
	logic              sclk;
	logic              mosi;
	logic              miso;

	// --------------------------------------------------
	// expected traffic
	// --------------------------------------------------
	int          cmd_wr [64];
	int          cmd_rd [64];
	int          cmd_rd_base [64];  // read bytes of all earlier commands
	int          cmd_n;
	logic [8:0]  exp_rd [256];      // {last, byte}
	int          exp_rd_n;
	logic [7:0]  exp_mosi [512];    // zeros during read bytes
	int          exp_mosi_n;
	int          out_idx;           // bytes taken from the output stream
	int          cur_t;             // transactions ended on the wire
	int          bits_seen;
	int          rec_total;
	logic [7:0]  rec_byte;
	logic [31:0] lcg_state;
	logic        cmd_sent;
	logic        slow_ready;
	int          stall_left;
	int          errors;
	int          err_base;
	int          tests_run;
	int          tests_failed;

	logic [8:0]  exp_out;
	logic [7:0]  exp_mosi_cur;
	int          exp_bits;
	int          wire_byte;
	int          rd_wire_idx;
	logic        in_read;

	assign exp_out      = exp_rd[out_idx];
	assign exp_mosi_cur = (rec_total > 0) ? exp_mosi[rec_total - 1] : 8'h00;
	assign exp_bits     = (cur_t > 0) ? 8 * (cmd_wr[cur_t - 1] + cmd_rd[cur_t - 1]) : 0;
	assign wire_byte    = (bits_seen - 1) / 8;
	assign in_read      = (bits_seen > 0) && (wire_byte >= cmd_wr[cur_t]);
	assign rd_wire_idx  = cmd_rd_base[cur_t] + wire_byte - cmd_wr[cur_t];

	spi_master_top #(
		.CLK_DIV   (CLK_DIV),
		.OUT_DEPTH (OUT_DEPTH)
	) dut_i (
		.aclk    (aclk),
		.aresetn (aresetn),
		.s_data  (s_data),
		.s_valid (s_valid),
		.s_ready (s_ready),
		.m_data  (m_data),
		.m_valid (m_valid),
		.m_ready (m_ready),
		.m_last  (m_last),
		.cs_n    (cs_n),
		.sclk    (sclk),
		.mosi    (mosi),
		.miso    (miso)
	);

	spi_flash_model flash_i (
		.cs_n      (cs_n),
		.sclk      (sclk),
		.mosi      (mosi),
		.wr_len    (cmd_wr[cur_t]),
		.miso      (miso),
		.bits_seen (bits_seen),
		.rec_total (rec_total),
		.rec_byte  (rec_byte)
	);

	always #(CLK_PERIOD / 2) aclk = !aclk;

	function automatic logic [31:0] rand_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return {lcg_state[15:0], lcg_state[31:16]};  // weak low bits moved up
	endfunction

	// consumer with long random stalls when slow_ready is set
	always @(posedge aclk) begin
		#DRIVE_DLY;
		if (!slow_ready) begin
			m_ready = 1'b1;
		end else if (stall_left > 0) begin
			m_ready    = 1'b0;
			stall_left = stall_left - 1;
		end else begin
			m_ready    = 1'b1;
			stall_left = int'(rand_next() % 128);
		end
	end

	always @(posedge aclk) begin
		if (m_valid && m_ready) begin
			out_idx <= out_idx + 1;
		end
	end

	always @(posedge cs_n) begin
		if (aresetn) begin
			cur_t <= cur_t + 1;
		end
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	a_quiet_before_cmd: assert property (@(posedge aclk) disable iff (!aresetn)
		!cmd_sent |-> (cs_n && !sclk && !m_valid))
	else begin
		$display("** Error: idle cs_n = %h, sclk = %h, m_valid = %h, expected 1, 0, 0",
			$sampled(cs_n), $sampled(sclk), $sampled(m_valid));
		errors++;
	end

	a_sclk_parked: assert property (@(posedge aclk) disable iff (!aresetn)
		cs_n |-> !sclk)
	else begin
		$display("** Error: sclk = %h while cs_n is high, expected 0", $sampled(sclk));
		errors++;
	end

	a_mosi_byte: assert property (@(posedge aclk) disable iff (!aresetn)
		(rec_total != $past(rec_total)) |-> (rec_byte == exp_mosi_cur))
	else begin
		$display("** Error: mosi byte %0d = %h, expected %h",
			$sampled(rec_total) - 1, $sampled(rec_byte), $sampled(exp_mosi_cur));
		errors++;
	end

	a_txn_size: assert property (@(posedge aclk) disable iff (!aresetn)
		$rose(cs_n) |-> (bits_seen == exp_bits))
	else begin
		$display("** Error: sclk rises in transaction = %h, expected %h",
			$sampled(bits_seen), $sampled(exp_bits));
		errors++;
	end

	a_read_data: assert property (@(posedge aclk) disable iff (!aresetn)
		(m_valid && m_ready) |-> (m_data == {{(WORD_W - BYTE_W){1'b0}}, exp_out[7:0]}))
	else begin
		$display("** Error: m_data = %h, expected %h", $sampled(m_data),
			{{(WORD_W - BYTE_W){1'b0}}, $sampled(exp_out[7:0])});
		errors++;
	end

	a_read_last: assert property (@(posedge aclk) disable iff (!aresetn)
		(m_valid && m_ready) |-> (m_last == exp_out[8]))
	else begin
		$display("** Error: m_last = %h, expected %h", $sampled(m_last), $sampled(exp_out[8]));
		errors++;
	end

	a_no_extra_read: assert property (@(posedge aclk) disable iff (!aresetn)
		m_valid |-> (out_idx < exp_rd_n))
	else begin
		$display("m_valid raised after all %0d expected read bytes", $sampled(exp_rd_n));
		errors++;
	end

	a_out_stable: assert property (@(posedge aclk) disable iff (!aresetn)
		(m_valid && !m_ready) |=> (m_valid && $stable(m_data) && $stable(m_last)))
	else begin
		$display("output word dropped or changed while m_ready was low");
		errors++;
	end

	// a read byte may only clock while the output FIFO has room for it
	a_no_clock_without_room: assert property (@(posedge aclk) disable iff (!aresetn)
		($rose(sclk) && in_read) |-> (rd_wire_idx < out_idx + OUT_DEPTH))
	else begin
		$display("sclk ran for read byte %0d with only %0d bytes taken",
			$sampled(rd_wire_idx), $sampled(out_idx));
		errors++;
	end

	// --------------------------------------------------
	// stimulus
	// --------------------------------------------------
	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge aclk);
			#DRIVE_DLY;
		end
	endtask

	task automatic send_word(input logic [WORD_W-1:0] w);
		s_data  = w;
		s_valid = 1'b1;
		do begin
			@(posedge aclk);
		end while (!s_ready);
		#DRIVE_DLY;
		s_valid = 1'b0;
	endtask

	task automatic issue_cmd(input int wr, input int rd, input logic gaps);
		logic [WORD_W-1:0] words [16];
		logic [WORD_W-1:0] cmd;
		for (int i = 0; i < wr; i++) begin
			words[i]               = rand_next();  // upper bits must be ignored
			exp_mosi[exp_mosi_n]   = words[i][7:0];
			exp_mosi_n++;
		end
		cmd_wr[cmd_n]      = wr;
		cmd_rd[cmd_n]      = rd;
		cmd_rd_base[cmd_n] = exp_rd_n;
		cmd_n++;
		for (int k = 0; k < rd; k++) begin
			exp_mosi[exp_mosi_n] = 8'h00;
			exp_mosi_n++;
			exp_rd[exp_rd_n] = {(k == rd - 1), 8'(165 + 29 * (wr + k))};
			exp_rd_n++;
		end
		cmd                         = '0;
		cmd[WR_LEN_LSB +: LEN_W]    = LEN_W'(wr);
		cmd[RD_LEN_LSB +: LEN_W]    = LEN_W'(rd);
		cmd_sent                    = 1'b1;
		send_word(cmd);
		for (int i = 0; i < wr; i++) begin
			if (gaps) begin
				idle_cycles(int'(rand_next() % 6));
			end
			send_word(words[i]);
		end
	endtask

	task automatic finish_test(input string name);
		wait ((out_idx == exp_rd_n) && (rec_total == exp_mosi_n) && (cur_t == cmd_n));
		idle_cycles(4);
		tests_run++;
		if (errors == err_base) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: FAILED, %0d errors", tests_run, name, errors - err_base);
		end
		err_base = errors;
	endtask

	initial begin
		lcg_state  = 32'd7;
		aresetn    = 1'b0;
		s_data     = '0;
		s_valid    = 1'b0;
		m_ready    = 1'b1;
		cmd_sent   = 1'b0;
		slow_ready = 1'b0;
		repeat (8) @(posedge aclk);
		#DRIVE_DLY;
		aresetn = 1'b1;

		idle_cycles(20);
		send_word('0);  // both counts zero, flash stays deselected
		idle_cycles(20);
		assert (s_ready) else begin
			$display("command with zero counts was not consumed");
			errors++;
		end
		finish_test("reset and idle");

		issue_cmd(4, 0, 1'b0);
		finish_test("write only");
		issue_cmd(0, 5, 1'b0);
		finish_test("read only");
		issue_cmd(3, 4, 1'b1);
		finish_test("mixed with input gaps");
		slow_ready = 1'b1;
		issue_cmd(0, 6, 1'b0);
		finish_test("read with output stalls");
		slow_ready = 1'b0;
		issue_cmd(2, 2, 1'b1);
		issue_cmd(1, 3, 1'b0);
		finish_test("back to back");

		$display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG);
		$display("watchdog expired after %0d time units, a test did not complete", WATCHDOG);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
common/spi_pkg.sv
common/spi_rx_if.sv
common/spi_shift_if.sv
spi_engine/spi_clock_gen.sv
spi_engine/spi_shifter.sv
spi_engine/spi_sequencer.sv
src/spi_in_buffer.sv
src/spi_out_buffer.sv
src/spi_master_top.sv
bench/spi_flash_model.sv
bench/tb_spi_master.sv

// ==== Bender.yml ====
package:
  name: spi_master

sources:
  - common/spi_pkg.sv
  - common/spi_rx_if.sv
  - common/spi_shift_if.sv
  - spi_engine/spi_clock_gen.sv
  - spi_engine/spi_shifter.sv
  - spi_engine/spi_sequencer.sv
  - src/spi_in_buffer.sv
  - src/spi_out_buffer.sv
  - src/spi_master_top.sv
  - target: simulation
    files:
      - bench/spi_flash_model.sv
      - bench/tb_spi_master.sv
